// File: rtl/fetch_pkg.sv
`default_nettype none

////////////////////
// Fetch package
// Widths, word types, memory geometry and
// the buffer state encoding of the fetch stage
////////////////////

package fetch_pkg;

  localparam int unsigned XLEN = 32;            // Data and address width

  typedef logic [XLEN-1:0] addr_t;              // Byte address
  typedef logic [XLEN-1:0] instr_t;             // Instruction word

  localparam addr_t BOOT_ADDR = 32'h8000_0000;  // First fetch after reset

  // Instruction memory geometry
  localparam int unsigned MEM_WORDS = 64;
  localparam int unsigned MEM_AW    = 6;        // Word index width

  typedef logic [MEM_AW-1:0] mem_idx_t;

  // Output / skid buffer states
  typedef enum logic [1:0] {
    FETCH_EMPTY,  // Nothing buffered
    FETCH_BUSY,   // Output register holds a word
    FETCH_FULL,   // Output and skid register both hold a word
    FETCH_JMP     // Redirect taken, waiting for first new request
  } fetch_state_e;

endpackage : fetch_pkg

`default_nettype wire

// File: rtl/instr_bus_if.sv
`timescale 1ns/100ps
`default_nettype none

////////////////////
// Instruction fetch bus
// Read request channel plus response channel,
// each with its own valid/ready pair
////////////////////

interface instr_bus_if import fetch_pkg::*; ();

  // Request channel
  addr_t  req_addr;   // Word aligned byte address
  logic   req_valid;
  logic   req_ready;

  // Response channel
  instr_t rsp_data;
  logic   rsp_error;  // Address not backed by memory
  logic   rsp_valid;
  logic   rsp_ready;

  // Fetch side
  modport fetcher (
    output req_addr, req_valid, rsp_ready,
    input  req_ready, rsp_data, rsp_error, rsp_valid
  );

  // Memory side
  modport memory (
    input  req_addr, req_valid, rsp_ready,
    output req_ready, rsp_data, rsp_error, rsp_valid
  );

endinterface : instr_bus_if

`default_nettype wire

// File: rtl/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

////////////////////
// Instruction fetch unit
// Issues word reads, buffers responses in a two entry
// skid buffer and feeds the decoder with word and PC
////////////////////

module fetch_unit import fetch_pkg::*; (
  input  wire logic   clk_i,
  input  wire logic   rstn_i,

  instr_bus_if.fetcher bus_o,           // Request/response bus to memory

  // Decoder side
  output instr_t      dec_instr_o,
  output addr_t       dec_pc_o,
  output logic        dec_err_o,        // Bus error on this word
  output logic        dec_valid_o,
  input  wire logic   dec_ready_i,

  // Redirect from execute
  input  wire logic   jmp_valid_i,
  input  wire addr_t  jmp_addr_i,

  output logic        ctrl_misalign_o,  // One cycle pulse
  output addr_t       ctrl_fault_addr_o
);

  // Handshakes
  logic req_fire;
  logic rsp_fire;
  logic dec_fire;
  logic rsp_take;    // Response kept, not discarded
  logic jump;        // Aligned redirect
  logic misalign;    // Low address bits set

  // FSM events
  logic load;
  logic flow;
  logic fill;
  logic unload;
  logic flush;
  logic restart;     // First request after redirect issued

  // Register enables and mux select
  logic out_en;
  logic skid_en;
  logic use_skid;

  fetch_state_e state_q, state_d;

  instr_t out_instr_q;
  logic   out_err_q;
  instr_t skid_instr_q;
  logic   skid_err_q;

  addr_t req_addr_q;       // Next request address
  addr_t pc_q;             // PC of word in output register

  logic [1:0] outstanding_q;  // Requests sent, response not yet seen
  logic [1:0] outstanding_d;
  logic [1:0] discard_q;      // Stale responses still to drop
  logic [1:0] buf_cnt;        // Words held in the buffers

  assign req_fire = bus_o.req_valid && bus_o.req_ready;
  assign rsp_fire = bus_o.rsp_valid && bus_o.rsp_ready;
  assign dec_fire = dec_valid_o && dec_ready_i;

  assign jump     = jmp_valid_i && (jmp_addr_i[1:0] == 2'b00);
  assign misalign = jmp_valid_i && (jmp_addr_i[1:0] != 2'b00);

  assign rsp_take = rsp_fire && (discard_q == 2'd0) && !jump;

  ////////////////////
  // Buffer FSM
  ////////////////////

  always_comb begin
    load    = (state_q == FETCH_EMPTY) &&  rsp_take;
    flow    = (state_q == FETCH_BUSY)  &&  rsp_take &&  dec_fire;
    fill    = (state_q == FETCH_BUSY)  &&  rsp_take && !dec_fire;
    unload  = (state_q == FETCH_BUSY)  && !rsp_take &&  dec_fire;
    flush   = (state_q == FETCH_FULL)  &&  dec_fire;
    restart = (state_q == FETCH_JMP)   &&  req_fire;
  end

  always_comb begin
    out_en   = load || flow || flush;
    skid_en  = fill;
    use_skid = flush;  // Skid word moves up
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH_EMPTY: if (load) state_d = FETCH_BUSY;
      FETCH_BUSY: begin
        if (fill) begin
          state_d = FETCH_FULL;
        end else if (unload) begin
          state_d = FETCH_EMPTY;
        end
      end
      FETCH_FULL:  if (flush) state_d = FETCH_BUSY;
      FETCH_JMP:   if (restart) state_d = FETCH_EMPTY;
      default:     state_d = FETCH_EMPTY;
    endcase
    if (jump) state_d = FETCH_JMP;  // Redirect wins
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q <= FETCH_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  // Output and skid registers, error bit rides along
  always_ff @(posedge clk_i) begin
    if (out_en) begin
      out_instr_q <= use_skid ? skid_instr_q : bus_o.rsp_data;
      out_err_q   <= use_skid ? skid_err_q   : bus_o.rsp_error;
    end
    if (skid_en) begin
      skid_instr_q <= bus_o.rsp_data;
      skid_err_q   <= bus_o.rsp_error;
    end
  end

  ////////////////////
  // Request side
  ////////////////////

  always_comb begin
    case (state_q)
      FETCH_BUSY: buf_cnt = 2'd1;
      FETCH_FULL: buf_cnt = 2'd2;
      default:    buf_cnt = 2'd0;  // EMPTY and JMP
    endcase
  end

  assign outstanding_d = outstanding_q + {1'b0, req_fire} - {1'b0, rsp_fire};

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      outstanding_q <= 2'd0;
      discard_q     <= 2'd0;
    end else begin
      outstanding_q <= outstanding_d;
      if (jump) begin
        discard_q <= outstanding_d;  // Everything in flight is stale
      end else if (rsp_fire && (discard_q != 2'd0)) begin
        discard_q <= discard_q - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      req_addr_q <= BOOT_ADDR;
    end else if (jump) begin
      req_addr_q <= jmp_addr_i;
    end else if (req_fire) begin
      req_addr_q <= req_addr_q + 32'd4;
    end
  end

  // Never more than two words owed or held
  assign bus_o.req_valid = ({1'b0, buf_cnt} + {1'b0, outstanding_q}) < 3'd2;
  assign bus_o.req_addr  = req_addr_q;
  assign bus_o.rsp_ready = (state_q != FETCH_FULL);

  ////////////////////
  // Decoder side
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      pc_q <= BOOT_ADDR;
    end else if (jump) begin
      pc_q <= jmp_addr_i;
    end else if (dec_fire) begin
      pc_q <= pc_q + 32'd4;
    end
  end

  assign dec_instr_o = out_instr_q;
  assign dec_err_o   = out_err_q;
  assign dec_pc_o    = pc_q;
  assign dec_valid_o = (state_q == FETCH_BUSY) || (state_q == FETCH_FULL);

  // Misaligned target, PC stays put
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      ctrl_misalign_o <= 1'b0;
    end else begin
      ctrl_misalign_o <= misalign;
    end
  end

  always_ff @(posedge clk_i) begin
    if (misalign) ctrl_fault_addr_o <= jmp_addr_i;
  end

endmodule : fetch_unit

`default_nettype wire

// File: rtl/instr_mem.sv
`timescale 1ns/100ps
`default_nettype none

////////////////////
// Instruction memory
// Single port word array, one cycle read latency,
// filled through a separate load port
////////////////////

module instr_mem import fetch_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     rstn_i,

  instr_bus_if.memory   bus_i,        // Fetch bus, read only

  // Load port
  input  wire logic     load_we_i,
  input  wire mem_idx_t load_idx_i,
  input  wire instr_t   load_data_i
);

  instr_t mem [MEM_WORDS];    // Word storage

  addr_t    offset;           // Byte offset from boot address
  mem_idx_t idx;              // Word index of request
  logic     in_range;

  logic req_fire;
  logic rsp_fire;
  logic rsp_valid_q;
  instr_t rsp_data_q;
  logic rsp_error_q;

  ////////////////////
  // Load port
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (load_we_i) mem[load_idx_i] <= load_data_i;
  end

  ////////////////////
  // Read path
  ////////////////////

  assign offset   = bus_i.req_addr - BOOT_ADDR;
  assign idx      = offset[MEM_AW+1:2];
  assign in_range = (offset[XLEN-1:MEM_AW+2] == '0);  // Below BOOT_ADDR wraps high

  assign req_fire = bus_i.req_valid && bus_i.req_ready;
  assign rsp_fire = rsp_valid_q && bus_i.rsp_ready;

  // Free when idle or the held answer leaves now
  assign bus_i.req_ready = !rsp_valid_q || bus_i.rsp_ready;

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;    // Back to back is fine
    end else if (rsp_fire) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Response payload, held until taken
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rsp_data_q  <= in_range ? mem[idx] : '0;
      rsp_error_q <= !in_range;
    end
  end

  assign bus_i.rsp_valid = rsp_valid_q;
  assign bus_i.rsp_data  = rsp_data_q;
  assign bus_i.rsp_error = rsp_error_q;

endmodule : instr_mem

`default_nettype wire

// File: rtl/fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

////////////////////
// Fetch subsystem top
// Fetch unit and instruction memory on one fetch bus
////////////////////

module fetch_top import fetch_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     rstn_i,

  // Memory load port
  input  wire logic     load_we_i,
  input  wire mem_idx_t load_idx_i,
  input  wire instr_t   load_data_i,

  // Decoder
  output instr_t        dec_instr_o,
  output addr_t         dec_pc_o,
  output logic          dec_err_o,
  output logic          dec_valid_o,
  input  wire logic     dec_ready_i,

  // Redirect and exception
  input  wire logic     jmp_valid_i,
  input  wire addr_t    jmp_addr_i,
  output logic          ctrl_misalign_o,
  output addr_t         ctrl_fault_addr_o
);

  instr_bus_if ibus ();   // Fetch to memory

  fetch_unit u_fetch (
    .clk_i             (clk_i),
    .rstn_i            (rstn_i),
    .bus_o             (ibus.fetcher),
    .dec_instr_o       (dec_instr_o),
    .dec_pc_o          (dec_pc_o),
    .dec_err_o         (dec_err_o),
    .dec_valid_o       (dec_valid_o),
    .dec_ready_i       (dec_ready_i),
    .jmp_valid_i       (jmp_valid_i),
    .jmp_addr_i        (jmp_addr_i),
    .ctrl_misalign_o   (ctrl_misalign_o),
    .ctrl_fault_addr_o (ctrl_fault_addr_o)
  );

  instr_mem u_mem (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .bus_i       (ibus.memory),
    .load_we_i   (load_we_i),
    .load_idx_i  (load_idx_i),
    .load_data_i (load_data_i)
  );

endmodule : fetch_top

`default_nettype wire

// File: test/fetch_asserts.sv
`timescale 1ns/100ps
`default_nettype none

////////////////////
// Fetch unit checks
// Handshake stability and exception pulse width
////////////////////

module fetch_asserts import fetch_pkg::*; (
  input wire logic   clk_i,
  input wire logic   rstn_i,
  input wire logic   req_valid_i,
  input wire logic   req_ready_i,
  input wire addr_t  req_addr_i,
  input wire logic   dec_valid_i,
  input wire logic   dec_ready_i,
  input wire instr_t dec_instr_i,
  input wire addr_t  dec_pc_i,
  input wire logic   dec_err_i,
  input wire logic   jmp_valid_i,
  input wire logic   misalign_i
);

  int unsigned fail_cnt = 0;  // Failed assertion count

  // Pending request holds until accepted unless redirected
  req_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
    req_valid_i && !req_ready_i && !jmp_valid_i |=> req_valid_i && $stable(req_addr_i))
    else begin
      $error("Fetch request changed before transfer");
      fail_cnt++;
    end

  // Stalled decoder word
  dec_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
    dec_valid_i && !dec_ready_i && !jmp_valid_i |=>
      dec_valid_i && $stable(dec_instr_i) && $stable(dec_pc_i) && $stable(dec_err_i))
    else begin
      $error("Decoder word changed while stalled");
      fail_cnt++;
    end

  // Exception is a single cycle pulse
  misalign_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
    misalign_i |=> !misalign_i)
    else begin
      $error("Misalign flag held for two cycles");
      fail_cnt++;
    end

endmodule : fetch_asserts

bind fetch_unit fetch_asserts u_asserts (
  .clk_i       (clk_i),
  .rstn_i      (rstn_i),
  .req_valid_i (bus_o.req_valid),
  .req_ready_i (bus_o.req_ready),
  .req_addr_i  (bus_o.req_addr),
  .dec_valid_i (dec_valid_o),
  .dec_ready_i (dec_ready_i),
  .dec_instr_i (dec_instr_o),
  .dec_pc_i    (dec_pc_o),
  .dec_err_i   (dec_err_o),
  .jmp_valid_i (jmp_valid_i),
  .misalign_i  (ctrl_misalign_o)
);

`default_nettype wire

// File: test/tb_fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

////////////////////
// Fetch stage testbench
// Directed tests of sequential fetch, stalls,
// redirects, misaligned targets and bus errors
////////////////////

module tb_fetch_top import fetch_pkg::*; ();

  localparam int TIMEOUT = 200;   // Cycles allowed per wait

  logic     clk_i;
  logic     rstn_i;
  logic     load_we_i;
  mem_idx_t load_idx_i;
  instr_t   load_data_i;
  instr_t   dec_instr_o;
  addr_t    dec_pc_o;
  logic     dec_err_o;
  logic     dec_valid_o;
  logic     dec_ready_i;
  logic     jmp_valid_i;
  addr_t    jmp_addr_i;
  logic     ctrl_misalign_o;
  addr_t    ctrl_fault_addr_o;

  addr_t exp_pc;    // Next PC the decoder should see

  fetch_top uut (
    .clk_i             (clk_i),
    .rstn_i            (rstn_i),
    .load_we_i         (load_we_i),
    .load_idx_i        (load_idx_i),
    .load_data_i       (load_data_i),
    .dec_instr_o       (dec_instr_o),
    .dec_pc_o          (dec_pc_o),
    .dec_err_o         (dec_err_o),
    .dec_valid_o       (dec_valid_o),
    .dec_ready_i       (dec_ready_i),
    .jmp_valid_i       (jmp_valid_i),
    .jmp_addr_i        (jmp_addr_i),
    .ctrl_misalign_o   (ctrl_misalign_o),
    .ctrl_fault_addr_o (ctrl_fault_addr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;  // 8 ns period
  end

  // Bound handshake checks end the run as well
  always @(posedge clk_i) begin
    if (uut.u_fetch.u_asserts.fail_cnt != 0) begin
      $display("Errors found");
      $fatal(1, "Stopped on assertion failure");
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  // Step to 1 ns past the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // Distinct memory word for every index
  function automatic instr_t word_at(int unsigned idx);
    return 32'h1000_0013 + idx * 32'h0102_0400;
  endfunction

  task automatic check_eq(string name, logic [31:0] exp, logic [31:0] act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
      $display("Errors found");
      $fatal(1, "Stopped on first mismatch");
    end
  endtask

  task automatic report_timeout(string what);
    $display("Timeout: %s never arrived within %0d cycles", what, TIMEOUT);
    $display("Errors found");
    $fatal(1, "Stopped on timeout");
  endtask

  // Compare one delivered word against the expected PC stream
  task automatic check_word(addr_t pc, instr_t instr, logic err);
    addr_t offset;
    offset = exp_pc - BOOT_ADDR;
    check_eq("dec_pc_o", exp_pc, pc);
    if (offset < MEM_WORDS * 4) begin
      check_eq("dec_instr_o", word_at(offset >> 2), instr);
      check_eq("dec_err_o", 32'd0, {31'd0, err});
    end else begin                          // Bus error outside memory
      check_eq("dec_instr_o", 32'd0, instr);
      check_eq("dec_err_o", 32'd1, {31'd0, err});
    end
    exp_pc = exp_pc + 32'd4;
  endtask

  // Hold ready until one word transfers
  task automatic take_word();
    int cycles;
    cycles = 0;
    dec_ready_i = 1'b1;
    while (!dec_valid_o) begin
      if (cycles == TIMEOUT) report_timeout("dec_valid_o");
      next_cycle();
      cycles++;
    end
    check_word(dec_pc_o, dec_instr_o, dec_err_o);
    next_cycle();                            // Transfer edge
    dec_ready_i = 1'b0;
  endtask

  // Single cycle redirect with the decoder stalled
  task automatic redirect(addr_t target);
    dec_ready_i = 1'b0;
    jmp_valid_i = 1'b1;
    jmp_addr_i  = target;
    next_cycle();
    jmp_valid_i = 1'b0;
  endtask

  task automatic load_program();
    for (int i = 0; i < MEM_WORDS; i++) begin
      load_we_i   = 1'b1;
      load_idx_i  = mem_idx_t'(i);
      load_data_i = word_at(i);
      next_cycle();
    end
    load_we_i = 1'b0;
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_sequential();
    exp_pc = BOOT_ADDR;
    repeat (16) take_word();
  endtask

  task automatic test_backpressure();
    int taken;
    int idle;
    taken = 0;
    idle  = 0;
    while (taken < 30) begin
      dec_ready_i = 1'($urandom % 2);        // Random stall
      if (dec_valid_o && dec_ready_i) begin
        check_word(dec_pc_o, dec_instr_o, dec_err_o);
        taken++;
        idle = 0;
      end else if (idle == TIMEOUT) begin
        report_timeout("dec_valid_o");
      end else begin
        idle++;
      end
      next_cycle();
    end
    dec_ready_i = 1'b0;
  endtask

  task automatic test_jump();
    addr_t target;
    target = BOOT_ADDR + 32'd160;            // Word 40
    dec_ready_i = 1'b1;
    repeat (3) begin                         // Keep requests in flight
      if (dec_valid_o) check_word(dec_pc_o, dec_instr_o, dec_err_o);
      next_cycle();
    end
    redirect(target);
    check_eq("dec_valid_o", 32'd0, {31'd0, dec_valid_o});  // Buffers flushed
    exp_pc = target;
    repeat (6) take_word();
  endtask

  task automatic test_misalign();
    addr_t bad;
    int    cycles;
    bad    = BOOT_ADDR + 32'd162;            // Word 40 plus 2
    cycles = 0;
    redirect(bad);
    while (!ctrl_misalign_o) begin
      if (cycles == TIMEOUT) report_timeout("ctrl_misalign_o");
      next_cycle();
      cycles++;
    end
    check_eq("ctrl_fault_addr_o", bad, ctrl_fault_addr_o);
    next_cycle();
    check_eq("ctrl_misalign_o", 32'd0, {31'd0, ctrl_misalign_o});
    repeat (6) take_word();                  // Stream goes on unchanged
  endtask

  task automatic test_bus_error();
    redirect(BOOT_ADDR + 32'd248);           // Word 62
    check_eq("dec_valid_o", 32'd0, {31'd0, dec_valid_o});
    exp_pc = BOOT_ADDR + 32'd248;
    repeat (6) take_word();                  // Two good words then faults
  endtask

  initial begin
    rstn_i      = 1'b0;
    load_we_i   = 1'b0;
    load_idx_i  = '0;
    load_data_i = '0;
    dec_ready_i = 1'b0;
    jmp_valid_i = 1'b0;
    jmp_addr_i  = '0;
    exp_pc      = BOOT_ADDR;
    void'($urandom(32'haa02));

    load_program();                          // Memory filled under reset
    repeat (5) next_cycle();

    // Reset state of the decoder side
    check_eq("dec_valid_o", 32'd0, {31'd0, dec_valid_o});
    check_eq("ctrl_misalign_o", 32'd0, {31'd0, ctrl_misalign_o});
    check_eq("dec_pc_o", BOOT_ADDR, dec_pc_o);
    rstn_i = 1'b1;

    test_sequential();
    test_backpressure();
    test_jump();
    test_misalign();
    test_bus_error();

    if (uut.u_fetch.u_asserts.fail_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule : tb_fetch_top

`default_nettype wire

// File: list.f
rtl/fetch_pkg.sv
rtl/instr_bus_if.sv
rtl/fetch_unit.sv
rtl/instr_mem.sv
rtl/fetch_top.sv
test/fetch_asserts.sv
test/tb_fetch_top.sv

// File: Bender.yml
package:
  name: fetch_stage

sources:
  - rtl/fetch_pkg.sv
  - rtl/instr_bus_if.sv
  - rtl/fetch_unit.sv
  - rtl/instr_mem.sv
  - rtl/fetch_top.sv
  - target: test
    files:
      - test/fetch_asserts.sv
      - test/tb_fetch_top.sv
